/* crc_ahb_pkg.sv */
/* Shared register map, bus codes, reset values and CR layout of the CRC unit.
   Imported by the RTL blocks and by the testbench */
package crc_ahb_pkg;

	////////////////////////////////////////////////////////////
	// Register map, word index from HADDR[4:2]
	////////////////////////////////////////////////////////////
	localparam logic [2:0] CRC_DR   = 3'h0;
	localparam logic [2:0] CRC_IDR  = 3'h1;
	localparam logic [2:0] CRC_CR   = 3'h2;
	localparam logic [2:0] CRC_INIT = 3'h4;
	localparam logic [2:0] CRC_POL  = 3'h5;

	// AHB transfer types
	localparam logic [1:0] HTRANS_IDLE   = 2'b00;
	localparam logic [1:0] HTRANS_BUSY   = 2'b01;
	localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
	localparam logic [1:0] HTRANS_SEQ    = 2'b11;

	// Only response ever given
	localparam logic HRESP_OK = 1'b0;

	// Low bits of HSIZE, kept with every buffered word
	localparam logic [1:0] SIZE_BYTE = 2'd0;
	localparam logic [1:0] SIZE_HALF = 2'd1;
	localparam logic [1:0] SIZE_WORD = 2'd2;

	// Polynomial width select
	localparam logic [1:0] POLY_32 = 2'd0;
	localparam logic [1:0] POLY_16 = 2'd1;
	localparam logic [1:0] POLY_8  = 2'd2;
	localparam logic [1:0] POLY_7  = 2'd3;

	// Input bit reversal granularity
	localparam logic [1:0] REV_NONE = 2'd0;
	localparam logic [1:0] REV_BYTE = 2'd1;
	localparam logic [1:0] REV_HALF = 2'd2;
	localparam logic [1:0] REV_WORD = 2'd3;

	// Values after HRESETn
	localparam logic [4:0]  RESET_CRC_CR = 5'h00;
	localparam logic [31:0] RESET_INIT   = 32'hFFFF_FFFF;
	localparam logic [31:0] RESET_POLY   = 32'h04C1_1DB7;
	localparam logic [7:0]  RESET_IDR    = 8'h00;

	// Entries in the DR write buffer
	localparam int BUF_DEPTH = 2;

	////////////////////////////////////////////////////////////
	// CR word, seen raw or as fields
	////////////////////////////////////////////////////////////
	typedef union packed {
		logic [31:0] word;
		struct packed {
			logic [23:0] reserved_hi;
			logic        rev_out;
			logic [1:0]  rev_in;
			logic [1:0]  poly_size;
			logic [1:0]  reserved_lo;
			logic        reset;
		} field;
	} crc_cr_u;

	// Number of CRC bits for a polynomial size code
	function automatic logic [5:0] poly_width(input logic [1:0] size);
		case (size)
			POLY_16: return 6'd16;
			POLY_8:  return 6'd8;
			POLY_7:  return 6'd7;
			default: return 6'd32;
		endcase
	endfunction

	// Ones over the low poly_width bits
	function automatic logic [31:0] poly_mask(input logic [1:0] size);
		if (size == POLY_32)
			return 32'hFFFF_FFFF;
		return (32'd1 << poly_width(size)) - 32'd1;
	endfunction

endpackage

/* crc_byte_step.sv */
/* One byte of CRC folding, bit-serial and MSB first, for a 32, 16, 8 or 7 bit
   polynomial. Purely combinational, chained inside the engine */
`timescale 1ns/1ps

module crc_byte_step
	import crc_ahb_pkg::*;
(
	input  logic [31:0] crc_in,
	input  logic [7:0]  data_byte,
	input  logic [31:0] poly,
	input  logic [1:0]  poly_size,
	input  logic        enable,
	output logic [31:0] crc_out
);

	logic [31:0] width_mask;
	logic [31:0] msb_mask;

	assign width_mask = poly_mask(poly_size);
	// Single bit at position W-1
	assign msb_mask   = width_mask ^ (width_mask >> 1);

	always_comb
	begin
		logic [31:0] crc;
		logic        feedback;

		crc = crc_in;
		for (int i = 7; i >= 0; i--)
		begin
			feedback = (|(crc & msb_mask)) ^ data_byte[i];
			// Upper bits fall out of the mask after the first shift
			crc = (crc << 1) & width_mask;
			if (feedback)
				crc = crc ^ (poly & width_mask);
		end
		// Disabled slice passes the state through
		crc_out = enable ? crc : crc_in;
	end

endmodule

/* host_interface.sv */
/* AHB-Lite slave front end of the CRC unit: register decode, CR register,
   read mux and the stall logic that holds the master in the data phase */
`timescale 1ns/1ps

module host_interface
	import crc_ahb_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic        HSElx,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	input  logic [31:0] crc_out,
	input  logic [31:0] crc_init_out,
	input  logic [31:0] crc_poly_out,
	input  logic [7:0]  crc_idr_out,
	input  logic        buffer_full,
	input  logic        reset_pending,
	input  logic        read_wait,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP,
	output logic [31:0] bus_wr,
	output logic [1:0]  bus_size,
	output logic [1:0]  rev_in_type,
	output logic        rev_out_type,
	output logic [1:0]  crc_poly_size,
	output logic        crc_init_en,
	output logic        crc_idr_en,
	output logic        crc_poly_en,
	output logic        buffer_write_en,
	output logic        reset_chain
);

	// Address phase copy
	logic [2:0] haddr_pp;
	logic [1:0] hsize_pp;
	logic [1:0] htrans_pp;
	logic       hwrite_pp;
	logic       hselx_pp;

	// Holds rev_out, rev_in and poly_size
	logic [4:0] crc_cr_ff;
	crc_cr_u    cr_wr;
	crc_cr_u    cr_rd;

	logic sample_bus;
	logic write_en;
	logic read_en;
	logic crc_cr_en;
	logic buffer_read_en;
	logic any_wr_en;

	////////////////////////////////////////////////////////////
	// Address phase pipeline
	////////////////////////////////////////////////////////////

	// Frozen while this slave stalls its own data phase
	assign sample_bus = HREADY && HREADYOUT;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			hselx_pp  <= 1'b0;
			htrans_pp <= HTRANS_IDLE;
		end
		else if (sample_bus)
		begin
			hselx_pp  <= HSElx;
			htrans_pp <= HTRANS;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (sample_bus)
		begin
			haddr_pp  <= HADDR[4:2];
			hsize_pp  <= HSIZE[1:0];
			hwrite_pp <= HWRITE;
		end
	end

	// Only NONSEQ transfers act
	assign write_en = hselx_pp && (htrans_pp == HTRANS_NONSEQ) && hwrite_pp;
	assign read_en  = hselx_pp && (htrans_pp == HTRANS_NONSEQ) && !hwrite_pp;

	// Per register enables in the data phase
	assign buffer_write_en = write_en && (haddr_pp == CRC_DR);
	assign crc_idr_en      = write_en && (haddr_pp == CRC_IDR);
	assign crc_cr_en       = write_en && (haddr_pp == CRC_CR);
	assign crc_init_en     = write_en && (haddr_pp == CRC_INIT);
	assign crc_poly_en     = write_en && (haddr_pp == CRC_POL);
	assign buffer_read_en  = read_en && (haddr_pp == CRC_DR);

	// Write data passes straight through in the data phase
	assign bus_wr   = HWDATA;
	assign bus_size = hsize_pp;

	////////////////////////////////////////////////////////////
	// Control register
	////////////////////////////////////////////////////////////
	assign cr_wr = HWDATA;

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
			crc_cr_ff <= RESET_CRC_CR;
		else if (crc_cr_en)
			crc_cr_ff <= {cr_wr.field.rev_out, cr_wr.field.rev_in, cr_wr.field.poly_size};
	end

	// Reset bit only fires the chain reset and is not stored
	assign reset_chain   = crc_cr_en && cr_wr.field.reset;
	assign crc_poly_size = crc_cr_ff[1:0];
	assign rev_in_type   = crc_cr_ff[3:2];
	assign rev_out_type  = crc_cr_ff[4];

	always_comb
	begin
		cr_rd                 = '0;
		cr_rd.field.rev_out   = crc_cr_ff[4];
		cr_rd.field.rev_in    = crc_cr_ff[3:2];
		cr_rd.field.poly_size = crc_cr_ff[1:0];
	end

	// Read data is combinational in the data phase
	always_comb
	begin
		case (haddr_pp)
			CRC_DR:   HRDATA = crc_out;
			CRC_IDR:  HRDATA = {24'h0, crc_idr_out};
			CRC_CR:   HRDATA = cr_rd.word;
			CRC_INIT: HRDATA = crc_init_out;
			CRC_POL:  HRDATA = crc_poly_out;
			default:  HRDATA = 32'h0;
		endcase
	end

	// Stall on full buffer, on DR read with data in flight,
	// and on INIT write while the old INIT is still needed
	assign HREADYOUT = !((buffer_write_en && buffer_full) ||
	                     (buffer_read_en && read_wait) ||
	                     (crc_init_en && reset_pending));

	assign HRESP = HRESP_OK;

	assign any_wr_en = buffer_write_en || crc_idr_en || crc_cr_en ||
	                   crc_init_en || crc_poly_en;

	// A stalled DR read is released once the data in flight has drained
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_read_en && read_wait |-> ##[1:BUF_DEPTH + 1] !read_wait);

	// Write data is known whenever a register write completes
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		any_wr_en && HREADYOUT |-> !$isunknown(HWDATA));

endmodule

/* crc_data_buffer.sv */
/* Two-entry FIFO for DR writes. The head word leaves bit-reversed according
   to the current CR input reversal setting */
`timescale 1ns/1ps

module crc_data_buffer
	import crc_ahb_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic        buffer_write_en,
	input  logic [31:0] bus_wr,
	input  logic [1:0]  bus_size,
	input  logic [1:0]  rev_in_type,
	input  logic        buf_ready,
	output logic        buffer_full,
	output logic        buf_valid,
	output logic [31:0] buf_data,
	output logic [1:0]  buf_size
);

	// Storage, no reset
	logic [31:0] data_mem [BUF_DEPTH];
	logic [1:0]  size_mem [BUF_DEPTH];

	logic [$clog2(BUF_DEPTH)-1:0]   wr_ptr;
	logic [$clog2(BUF_DEPTH)-1:0]   rd_ptr;
	logic [$clog2(BUF_DEPTH+1)-1:0] count;
	logic                           push;
	logic                           pop;
	logic [31:0]                    head_data;
	logic [1:0]                     rev_eff;

	assign buffer_full = (count == BUF_DEPTH);
	assign buf_valid   = (count != 0);

	// Master is stalled while full, so a held write lands later
	assign push = buffer_write_en && !buffer_full;
	assign pop  = buf_valid && buf_ready;

	always_ff @(posedge HCLK)
	begin
		if (push)
		begin
			data_mem[wr_ptr] <= bus_wr;
			size_mem[wr_ptr] <= bus_size;
		end
	end

	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count  <= '0;
		end
		else
		begin
			if (push)
				wr_ptr <= (wr_ptr == BUF_DEPTH - 1) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == BUF_DEPTH - 1) ? '0 : rd_ptr + 1'b1;
			case ({push, pop})
				2'b10:   count <= count + 1'b1;
				2'b01:   count <= count - 1'b1;
				default: count <= count;
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// Output side reversal
	////////////////////////////////////////////////////////////
	assign head_data = data_mem[rd_ptr];
	assign buf_size  = size_mem[rd_ptr];

	// Reversal unit is capped at the write size,
	// so a byte write never leaves its low lane
	assign rev_eff = (rev_in_type > buf_size + 2'd1) ? buf_size + 2'd1 : rev_in_type;

	always_comb
	begin
		for (int i = 0; i < 32; i++)
		begin
			case (rev_eff)
				// XOR of the bit index mirrors it inside the unit
				REV_BYTE: buf_data[i] = head_data[i ^ 7];
				REV_HALF: buf_data[i] = head_data[i ^ 15];
				REV_WORD: buf_data[i] = head_data[i ^ 31];
				default:  buf_data[i] = head_data[i];
			endcase
		end
	end

	// A write refused on full is held by the host stall
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		buffer_write_en && buffer_full |=> buffer_write_en);

endmodule

/* crc_engine.sv */
/* CRC state with its INIT, POL and IDR registers. Folds one buffered beat of up
   to four bytes per cycle and applies the deferred chain reset */
`timescale 1ns/1ps

module crc_engine
	import crc_ahb_pkg::*;
(
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] bus_wr,
	input  logic        crc_init_en,
	input  logic        crc_poly_en,
	input  logic        crc_idr_en,
	input  logic        reset_chain,
	input  logic [1:0]  crc_poly_size,
	input  logic        buf_valid,
	input  logic [31:0] buf_data,
	input  logic [1:0]  buf_size,
	output logic        buf_ready,
	output logic [31:0] crc_state,
	output logic [31:0] crc_init_out,
	output logic [31:0] crc_poly_out,
	output logic [7:0]  crc_idr_out,
	output logic        reset_pending,
	output logic        engine_busy
);

	logic [31:0] crc_init_ff;
	logic [31:0] crc_poly_ff;
	logic [7:0]  crc_idr_ff;
	logic        pend_ff;
	logic        reset_load;
	logic        beat;
	logic [2:0]  n_bytes;
	wire  [31:0] crc_chain [0:4];

	// Reset waits for the data written before it
	assign reset_load = pend_ff && !buf_valid;
	assign buf_ready  = !reset_load;
	assign beat       = buf_valid && buf_ready;

	// Folding or a pending reset both hold off DR reads
	assign engine_busy   = beat || pend_ff;
	assign reset_pending = pend_ff;

	always_comb
	begin
		case (buf_size)
			SIZE_BYTE: n_bytes = 3'd1;
			SIZE_HALF: n_bytes = 3'd2;
			default:   n_bytes = 3'd4;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Byte slices, most significant valid byte first
	////////////////////////////////////////////////////////////
	assign crc_chain[0] = crc_state;

	for (genvar k = 0; k < 4; k++)
	begin : g_step
		logic [1:0] byte_sel;

		// Byte n-1-k wraps harmlessly when the slice is off
		assign byte_sel = n_bytes[1:0] - 2'd1 - 2'(k);

		crc_byte_step u_step (
			.crc_in    (crc_chain[k]),
			.data_byte (buf_data[8*byte_sel +: 8]),
			.poly      (crc_poly_ff),
			.poly_size (crc_poly_size),
			.enable    (k < n_bytes),
			.crc_out   (crc_chain[k+1])
		);
	end

	// CRC state and chain reset flag
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_state <= RESET_INIT;
			pend_ff   <= 1'b0;
		end
		else
		begin
			if (reset_load)
				crc_state <= crc_init_ff;
			else if (beat)
				crc_state <= crc_chain[4];
			if (reset_chain)
				pend_ff <= 1'b1;
			else if (reset_load)
				pend_ff <= 1'b0;
		end
	end

	// Configuration registers
	always_ff @(posedge HCLK)
	begin
		if (!HRESETn)
		begin
			crc_init_ff <= RESET_INIT;
			crc_poly_ff <= RESET_POLY;
			crc_idr_ff  <= RESET_IDR;
		end
		else
		begin
			// INIT write is stalled until the pending load used the old value
			if (crc_init_en && !pend_ff)
				crc_init_ff <= bus_wr;
			if (crc_poly_en)
				crc_poly_ff <= bus_wr;
			if (crc_idr_en)
				crc_idr_ff <= bus_wr[7:0];
		end
	end

	assign crc_init_out = crc_init_ff;
	assign crc_poly_out = crc_poly_ff;
	assign crc_idr_out  = crc_idr_ff;

	// A chain reset is applied once the data queued before it has drained
	assert property (@(posedge HCLK) disable iff (!HRESETn)
		reset_chain |-> ##[1:BUF_DEPTH] reset_load);

endmodule

/* crc_result_format.sv */
/* Shapes the CRC state for DR reads. Keeps only the polynomial width and can
   mirror those bits, upper bits read as zero */
`timescale 1ns/1ps

module crc_result_format
	import crc_ahb_pkg::*;
(
	input  logic [31:0] crc_state,
	input  logic [1:0]  crc_poly_size,
	input  logic        rev_out_type,
	output logic [31:0] crc_out
);

	logic [5:0]  width;
	logic [31:0] masked;
	logic [31:0] mirrored;

	assign width  = poly_width(crc_poly_size);
	assign masked = crc_state & poly_mask(crc_poly_size);

	// Full word mirror first
	always_comb
	begin
		for (int i = 0; i < 32; i++)
			mirrored[i] = masked[31 - i];
	end

	// Shift brings the W mirrored bits back down
	assign crc_out = rev_out_type ? (mirrored >> (6'd32 - width)) : masked;

endmodule

/* crc_ahb_top.sv */
/* CRC calculator on an AHB-Lite slave port. Ties the host interface, write
   buffer, engine and result formatter together */
`timescale 1ns/1ps

module crc_ahb_top (
	input  logic        HCLK,
	input  logic        HRESETn,
	input  logic [31:0] HADDR,
	input  logic [2:0]  HSIZE,
	input  logic [1:0]  HTRANS,
	input  logic        HWRITE,
	input  logic        HSElx,
	input  logic        HREADY,
	input  logic [31:0] HWDATA,
	output logic [31:0] HRDATA,
	output logic        HREADYOUT,
	output logic        HRESP
);

	logic [31:0] bus_wr;
	logic [1:0]  bus_size;
	logic [1:0]  rev_in_type;
	logic        rev_out_type;
	logic [1:0]  crc_poly_size;
	logic        crc_init_en;
	logic        crc_idr_en;
	logic        crc_poly_en;
	logic        buffer_write_en;
	logic        reset_chain;
	logic        buffer_full;
	logic        buf_valid;
	logic        buf_ready;
	logic [31:0] buf_data;
	logic [1:0]  buf_size;
	logic [31:0] crc_state;
	logic [31:0] crc_out;
	logic [31:0] crc_init_out;
	logic [31:0] crc_poly_out;
	logic [7:0]  crc_idr_out;
	logic        reset_pending;
	logic        engine_busy;
	logic        read_wait;

	// DR reads wait for queued data and any fold or reset in progress
	assign read_wait = buf_valid || engine_busy;

	host_interface u_host (
		.HCLK, .HRESETn, .HADDR, .HSIZE, .HTRANS, .HWRITE, .HSElx, .HREADY, .HWDATA,
		.crc_out, .crc_init_out, .crc_poly_out, .crc_idr_out,
		.buffer_full, .reset_pending, .read_wait,
		.HRDATA, .HREADYOUT, .HRESP,
		.bus_wr, .bus_size, .rev_in_type, .rev_out_type, .crc_poly_size,
		.crc_init_en, .crc_idr_en, .crc_poly_en, .buffer_write_en, .reset_chain
	);

	crc_data_buffer u_buffer (
		.HCLK, .HRESETn, .buffer_write_en, .bus_wr, .bus_size, .rev_in_type,
		.buf_ready, .buffer_full, .buf_valid, .buf_data, .buf_size
	);

	crc_engine u_engine (
		.HCLK, .HRESETn, .bus_wr, .crc_init_en, .crc_poly_en, .crc_idr_en,
		.reset_chain, .crc_poly_size, .buf_valid, .buf_data, .buf_size,
		.buf_ready, .crc_state, .crc_init_out, .crc_poly_out, .crc_idr_out,
		.reset_pending, .engine_busy
	);

	crc_result_format u_format (
		.crc_state, .crc_poly_size, .rev_out_type, .crc_out
	);

endmodule

/* crc_ahb_tb.sv */
/* Self-checking testbench of the AHB-Lite CRC unit. Queued transfers run pipelined
   on the bus and every read is compared with a reference model of the register rules */
`timescale 1ns/1ps

module crc_ahb_tb;
	import crc_ahb_pkg::*;

	// Cycles a single data phase may stall
	localparam int READY_TIMEOUT = 200;

	logic        HCLK;
	logic        HRESETn;
	logic [31:0] HADDR;
	logic [2:0]  HSIZE;
	logic [1:0]  HTRANS;
	logic        HWRITE;
	logic        HSElx;
	wire         HREADY;
	logic [31:0] HWDATA;
	logic [31:0] HRDATA;
	logic        HREADYOUT;
	logic        HRESP;

	// Single slave drives the bus ready
	assign HREADY = HREADYOUT;

	crc_ahb_top uut (
		.HCLK, .HRESETn, .HADDR, .HSIZE, .HTRANS, .HWRITE, .HSElx, .HREADY, .HWDATA,
		.HRDATA, .HREADYOUT, .HRESP
	);

	always #10 HCLK = ~HCLK;

	// Model of the register file and CRC state
	logic [31:0] lfsr_q;
	logic [31:0] m_state;
	logic [31:0] m_init;
	logic [31:0] m_poly;
	logic [7:0]  m_idr;
	logic        m_rev_out;
	logic [1:0]  m_rev_in;
	logic [1:0]  m_psize;

	// Pending transfers with one entry per AHB transfer
	logic        q_write [$];
	logic [2:0]  q_idx [$];
	logic [1:0]  q_size [$];
	logic [31:0] q_data [$];
	logic        q_sel [$];
	logic [1:0]  q_trans [$];
	logic [31:0] q_exp [$];

	// Handoff to the compare process
	logic [31:0] rd_got;
	logic [31:0] rd_exp;
	logic [31:0] last_rd;
	string       rd_msg;
	event        read_done;

	////////////////////////////////////////////////////////////
	// Reference model
	////////////////////////////////////////////////////////////

	// Galois LFSR stepped once per bit taken
	function automatic logic [31:0] lfsr_take(input int n);
		logic [31:0] r;
		logic        b;

		r = '0;
		for (int i = 0; i < n; i++)
		begin
			b      = lfsr_q[0];
			lfsr_q = lfsr_q >> 1;
			if (b)
				lfsr_q = lfsr_q ^ 32'h8020_0003;
			r = {r[30:0], b};
		end
		return r;
	endfunction

	function automatic int width_of(input logic [1:0] psize);
		case (psize)
			2'd1:    return 16;
			2'd2:    return 8;
			2'd3:    return 7;
			default: return 32;
		endcase
	endfunction

	function automatic logic [31:0] mask_of(input int w);
		return (w == 32) ? 32'hFFFF_FFFF : ((32'd1 << w) - 32'd1);
	endfunction

	// MSB-first shift register over one byte
	function automatic logic [31:0] fold_byte(input logic [31:0] st, input logic [7:0] b);
		int          w;
		logic [31:0] mask;
		logic        fb;

		w    = width_of(m_psize);
		mask = mask_of(w);
		for (int i = 7; i >= 0; i--)
		begin
			fb = st[w-1] ^ b[i];
			st = (st << 1) & mask;
			if (fb)
				st = st ^ (m_poly & mask);
		end
		return st;
	endfunction

	// One DR write with the reversal unit capped at the write size
	function automatic logic [31:0] fold_write(input logic [31:0] st, input logic [31:0] data,
		input logic [1:0] size);
		int          unit;
		int          n;
		logic [31:0] d;

		unit = (m_rev_in == 2'd3) ? 32 : (m_rev_in == 2'd2) ? 16 : (m_rev_in == 2'd1) ? 8 : 0;
		if (size == SIZE_BYTE && unit > 8)
			unit = 8;
		if (size == SIZE_HALF && unit > 16)
			unit = 16;
		n = (size == SIZE_BYTE) ? 1 : (size == SIZE_HALF) ? 2 : 4;
		d = data;
		if (unit != 0)
		begin
			for (int i = 0; i < 32; i++)
				d[i] = data[(i / unit) * unit + unit - 1 - (i % unit)];
		end
		// Highest valid byte goes in first
		for (int k = n - 1; k >= 0; k--)
			st = fold_byte(st, d[8*k +: 8]);
		return st;
	endfunction

	// Value a DR read returns for a given state
	function automatic logic [31:0] crc_ref(input logic [31:0] st);
		int          w;
		logic [31:0] m;
		logic [31:0] r;

		w = width_of(m_psize);
		m = st & mask_of(w);
		r = '0;
		if (!m_rev_out)
			return m;
		for (int i = 0; i < w; i++)
			r[i] = m[w-1-i];
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// Checks and bus master
	////////////////////////////////////////////////////////////
	task automatic compare_values(input logic [31:0] got, input logic [31:0] exp,
		input string msg);
		if (got !== exp)
		begin
			$display("ERR %0t: %s got %h expected %h", $time, msg, got, exp);
			$display("RESULT: FAIL");
			$fatal(1, "Stopped on data mismatch");
		end
	endtask

	// Every completed read is checked here
	always @(read_done)
		compare_values(rd_got, rd_exp, rd_msg);

	task automatic push_transfer(input logic write, input logic [2:0] idx,
		input logic [1:0] size, input logic [31:0] data, input logic sel,
		input logic [1:0] trans, input logic [31:0] exp);
		q_write.push_back(write);
		q_idx.push_back(idx);
		q_size.push_back(size);
		q_data.push_back(data);
		q_sel.push_back(sel);
		q_trans.push_back(trans);
		q_exp.push_back(exp);
	endtask

	// Queues a register write and applies it to the model in bus order
	task automatic write_reg(input logic [2:0] idx, input logic [1:0] size,
		input logic [31:0] data);
		case (idx)
			CRC_DR:   m_state = fold_write(m_state, data, size);
			CRC_IDR:  m_idr = data[7:0];
			CRC_INIT: m_init = data;
			CRC_POL:  m_poly = data;
			CRC_CR:
			begin
				m_rev_out = data[7];
				m_rev_in  = data[6:5];
				m_psize   = data[4:3];
				// Reset bit restarts from the INIT value held now
				if (data[0])
					m_state = m_init;
			end
			default: ;
		endcase
		push_transfer(1'b1, idx, size, data, 1'b1, HTRANS_NONSEQ, 32'h0);
	endtask

	task automatic read_reg(input logic [2:0] idx);
		logic [31:0] exp;

		case (idx)
			CRC_DR:   exp = crc_ref(m_state);
			CRC_IDR:  exp = {24'h0, m_idr};
			CRC_CR:   exp = {24'h0, m_rev_out, m_rev_in, m_psize, 3'b000};
			CRC_INIT: exp = m_init;
			CRC_POL:  exp = m_poly;
			default:  exp = 32'h0;
		endcase
		push_transfer(1'b0, idx, SIZE_WORD, 32'h0, 1'b1, HTRANS_NONSEQ, exp);
	endtask

	// Write the slave must not act on
	task automatic ignored_write(input logic [2:0] idx, input logic [31:0] data,
		input logic sel, input logic [1:0] trans);
		push_transfer(1'b1, idx, SIZE_WORD, data, sel, trans, 32'h0);
	endtask

	// Sampled mid-cycle where HREADYOUT and HRDATA are settled
	task automatic wait_hreadyout(output logic [31:0] rd);
		int cycles;

		cycles = 0;
		@(negedge HCLK);
		while (HREADYOUT !== 1'b1)
		begin
			cycles++;
			if (cycles > READY_TIMEOUT)
			begin
				$display("HREADYOUT stayed low too long, the bus transfer never finished");
				$display("RESULT: FAIL");
				$fatal(1, "Timeout on AHB data phase");
			end
			@(negedge HCLK);
		end
		rd = HRDATA;
	endtask

	// Address phase of transfer i overlaps the data phase of i-1
	task automatic run_transfers();
		int          n;
		logic [31:0] rd;

		n = q_idx.size();
		@(posedge HCLK);
		for (int i = 0; i <= n; i++)
		begin
			if (i < n)
			begin
				HADDR  <= {27'h0, q_idx[i], 2'b00};
				HSIZE  <= {1'b0, q_size[i]};
				HTRANS <= q_trans[i];
				HWRITE <= q_write[i];
				HSElx  <= q_sel[i];
			end
			else
			begin
				HTRANS <= HTRANS_IDLE;
				HSElx  <= 1'b0;
			end
			if (i > 0 && q_write[i-1])
				HWDATA <= q_data[i-1];
			wait_hreadyout(rd);
			compare_values({31'h0, HRESP}, {31'h0, HRESP_OK}, "AHB response");
			if (i > 0 && !q_write[i-1])
			begin
				rd_got  = rd;
				rd_exp  = q_exp[i-1];
				rd_msg  = $sformatf("read of register index %0d", q_idx[i-1]);
				last_rd = rd;
				-> read_done;
			end
			@(posedge HCLK);
		end
		q_write.delete();
		q_idx.delete();
		q_size.delete();
		q_data.delete();
		q_sel.delete();
		q_trans.delete();
		q_exp.delete();
	endtask

	////////////////////////////////////////////////////////////
	// Test sequence
	////////////////////////////////////////////////////////////
	initial
	begin
		logic [2:0]  regs [5];
		logic [1:0]  psz;
		logic [1:0]  sz;
		int          cnt;

		HCLK    = 1'b0;
		HRESETn = 1'b0;
		HADDR   = 32'h0;
		HSIZE   = 3'd0;
		HTRANS  = HTRANS_IDLE;
		HWRITE  = 1'b0;
		HSElx   = 1'b0;
		HWDATA  = 32'h0;
		lfsr_q  = 32'h8d1;
		regs    = '{CRC_DR, CRC_IDR, CRC_CR, CRC_INIT, CRC_POL};

		// Model after reset
		m_state   = 32'hFFFF_FFFF;
		m_init    = 32'hFFFF_FFFF;
		m_poly    = 32'h04C1_1DB7;
		m_idr     = 8'h00;
		m_rev_out = 1'b0;
		m_rev_in  = 2'd0;
		m_psize   = 2'd0;

		repeat (3) @(posedge HCLK);
		HRESETn <= 1'b1;

		// Reset values
		for (int i = 0; i < 5; i++)
			read_reg(regs[i]);
		run_transfers();

		// Register write and read-back with random CR reserved bits
		write_reg(CRC_IDR, SIZE_WORD, lfsr_take(32));
		write_reg(CRC_INIT, SIZE_WORD, lfsr_take(32));
		write_reg(CRC_POL, SIZE_WORD, lfsr_take(32));
		write_reg(CRC_CR, SIZE_WORD, lfsr_take(32));
		for (int i = 0; i < 5; i++)
			read_reg(regs[i]);
		run_transfers();

		// Word streams for each polynomial width
		for (int p = 0; p < 4; p++)
		begin
			write_reg(CRC_POL, SIZE_WORD, lfsr_take(32) | 32'h1);
			write_reg(CRC_INIT, SIZE_WORD, lfsr_take(32));
			write_reg(CRC_CR, SIZE_WORD, {27'h0, 2'(p), 3'b001});
			for (int j = 0; j < 6; j++)
				write_reg(CRC_DR, SIZE_WORD, lfsr_take(32));
			read_reg(CRC_DR);
			run_transfers();
		end

		// Standard CRC-32 of 123456789 before its final XOR
		write_reg(CRC_POL, SIZE_WORD, 32'h04C1_1DB7);
		write_reg(CRC_INIT, SIZE_WORD, 32'hFFFF_FFFF);
		write_reg(CRC_CR, SIZE_WORD, {24'h0, 1'b1, REV_BYTE, POLY_32, 3'b001});
		for (int j = 0; j < 9; j++)
			write_reg(CRC_DR, SIZE_BYTE, 32'h31 + j);
		read_reg(CRC_DR);
		run_transfers();
		compare_values(last_rd ^ 32'hFFFF_FFFF, 32'hCBF4_3926, "CRC-32 check value");

		// Mixed sizes over all input reversals with output reversal off then on
		for (int r = 0; r < 8; r++)
		begin
			psz = 2'(lfsr_take(2));
			write_reg(CRC_CR, SIZE_WORD, {24'h0, (r >= 4), 2'(r % 4), psz, 3'b001});
			cnt = 3 + lfsr_take(3);
			for (int j = 0; j < cnt; j++)
			begin
				sz = 2'(lfsr_take(2));
				if (sz == 2'd3)
					sz = SIZE_WORD;
				write_reg(CRC_DR, sz, lfsr_take(32));
			end
			read_reg(CRC_DR);
			run_transfers();
		end

		// One stream with a DR read behind the writes and an INIT write behind a chain reset
		write_reg(CRC_CR, SIZE_WORD, {24'h0, 1'b1, REV_WORD, POLY_16, 3'b001});
		for (int j = 0; j < 5; j++)
			write_reg(CRC_DR, SIZE_WORD, lfsr_take(32));
		read_reg(CRC_DR);
		write_reg(CRC_CR, SIZE_WORD, {24'h0, 1'b0, REV_HALF, POLY_8, 3'b001});
		write_reg(CRC_INIT, SIZE_WORD, lfsr_take(32));
		for (int j = 0; j < 3; j++)
			write_reg(CRC_DR, SIZE_HALF, lfsr_take(32));
		read_reg(CRC_DR);
		read_reg(CRC_INIT);
		run_transfers();

		// Unselected and IDLE writes leave everything as it was
		for (int i = 0; i < 5; i++)
		begin
			ignored_write(regs[i], lfsr_take(32), 1'b0, HTRANS_NONSEQ);
			ignored_write(regs[i], lfsr_take(32), 1'b1, HTRANS_IDLE);
		end
		for (int i = 0; i < 5; i++)
			read_reg(regs[i]);
		run_transfers();

		repeat (2) @(posedge HCLK);
		$display("RESULT: PASS");
		$finish;
	end

endmodule

/* crc_ahb_top.f */
crc_ahb_pkg.sv
crc_byte_step.sv
host_interface.sv
crc_data_buffer.sv
crc_engine.sv
crc_result_format.sv
crc_ahb_top.sv
crc_ahb_tb.sv

/* Bender.yml */
package:
  name: crc_ahb

sources:
  - crc_ahb_pkg.sv
  - crc_byte_step.sv
  - host_interface.sv
  - crc_data_buffer.sv
  - crc_engine.sv
  - crc_result_format.sv
  - crc_ahb_top.sv
  - target: test
    files:
      - crc_ahb_tb.sv
